// File: hw/fp_format_pkg.sv
package fp_format_pkg;

   ////////////////////
   // binary32 layout
   ////////////////////

   // Sign, biased exponent, fraction
   typedef struct packed {
      logic        sign;
      logic [7:0]  exp;
      logic [22:0] man;
   } fp_fields_t;

   localparam int          EXP_BIAS       = 127;
   localparam int          EXP_MAX        = 255;
   // Quiet NaN returned for every NaN result
   localparam logic [31:0] CANON_NAN      = 32'h7fc00000;
   // Largest finite magnitude without the sign bit
   localparam logic [30:0] MAX_FINITE_MAG = 31'h7f7fffff;

   ////////////////////
   // Classification
   ////////////////////

   // Subnormals fall in here too
   function automatic logic is_zero(input fp_fields_t f);
      return f.exp == 8'd0;
   endfunction

   function automatic logic is_inf(input fp_fields_t f);
      return (f.exp == 8'(EXP_MAX)) && (f.man == 23'd0);
   endfunction

   function automatic logic is_nan(input fp_fields_t f);
      return (f.exp == 8'(EXP_MAX)) && (f.man != 23'd0);
   endfunction

endpackage

// File: hw/fpu_ctrl_pkg.sv
package fpu_ctrl_pkg;

   ////////////////////
   // Opcodes
   ////////////////////

   typedef enum logic [1:0] {
      FPU_ADD = 2'd0,
      FPU_SUB = 2'd1,
      FPU_MUL = 2'd2,
      FPU_DIV = 2'd3
   } fpu_op_e;

   // Exception flags, inexact not tracked
   typedef struct packed {
      logic nv;
      logic dz;
      logic of;
      logic uf;
   } fpu_flags_t;

   // Request as seen by both units
   typedef struct packed {
      fpu_op_e     op;
      logic [31:0] a;
      logic [31:0] b;
   } fpu_req_t;

   typedef struct packed {
      logic [31:0] result;
      fpu_flags_t  flags;
   } fpu_rsp_t;

endpackage

// File: hw/fp_addmul_core.sv
`timescale 1ns/100ps

module fp_addmul_core #(
   parameter int unsigned TAG_W = 4
) (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   en_i,
   input  fpu_ctrl_pkg::fpu_req_t req_i,
   input  logic [TAG_W-1:0]       tag_i,
   output logic                   valid_o,
   output fpu_ctrl_pkg::fpu_rsp_t rsp_o,
   output logic [TAG_W-1:0]       tag_o,
   output logic                   occupied_o
);
   import fp_format_pkg::*;
   import fpu_ctrl_pkg::*;

   // Operands, b already negated for SUB
   fp_fields_t        fa;
   fp_fields_t        fb;
   logic              a_zero, b_zero;
   logic              a_inf, b_inf;
   logic              a_nan, b_nan;
   logic signed [9:0] ea, eb;

   // Add path
   logic              a_big;
   fp_fields_t        fl;
   fp_fields_t        fs;
   logic [7:0]        exp_diff;
   logic [4:0]        shamt;
   logic [53:0]       align_full;
   logic [26:0]       align_m;
   logic [27:0]       add_sum;

   // Mul path
   logic [47:0]       mul_prod;

   // Stage 1 next values and registers
   logic              s1_sign_d;
   logic signed [9:0] s1_exp_d;
   logic [47:0]       s1_mant_d;
   logic              s1_spec_d;
   fpu_rsp_t          s1_spec_rsp_d;

   logic              s1_valid;
   logic [TAG_W-1:0]  s1_tag;
   logic              s1_sign;
   logic signed [9:0] s1_exp;
   logic [47:0]       s1_mant;
   logic              s1_spec;
   fpu_rsp_t          s1_spec_rsp;

   // Stage 2
   logic [5:0]        lz;
   logic [47:0]       norm;
   logic signed [9:0] exp_n;
   fpu_rsp_t          s2_rsp_d;
   logic              s2_valid;
   logic [TAG_W-1:0]  s2_tag;
   fpu_rsp_t          s2_rsp;

   // Leading zero count, 48 for an all-zero word
   function automatic logic [5:0] lead_zeros(input logic [47:0] v);
      logic [5:0] n;
      logic       hit;
      n   = 6'd48;
      hit = 1'b0;
      for (int i = 47; i >= 0; i--) begin
         if (!hit && v[i]) begin
            n   = 6'(47 - i);
            hit = 1'b1;
         end
      end
      return n;
   endfunction

   ////////////////////
   // Stage 1
   ////////////////////

   always_comb begin
      fa = req_i.a;
      fb = req_i.b;
      // Subtract is add with b negated
      if (req_i.op == FPU_SUB) begin
         fb.sign = ~req_i.b[31];
      end
   end

   assign a_zero = is_zero(fa);
   assign b_zero = is_zero(fb);
   assign a_inf  = is_inf(fa);
   assign b_inf  = is_inf(fb);
   assign a_nan  = is_nan(fa);
   assign b_nan  = is_nan(fb);
   assign ea     = {2'b00, fa.exp};
   assign eb     = {2'b00, fb.exp};

   // Larger magnitude first so alignment only shifts right
   assign a_big    = {fa.exp, fa.man} >= {fb.exp, fb.man};
   assign fl       = a_big ? fa : fb;
   assign fs       = a_big ? fb : fa;
   assign exp_diff = fl.exp - fs.exp;
   // Beyond 27 everything lands in sticky anyway
   assign shamt    = (exp_diff > 8'd27) ? 5'd27 : exp_diff[4:0];

   // Hidden bit, fraction, guard/round/sticky slots, then spill area
   assign align_full = {1'b1, fs.man, 3'b000, 27'd0} >> shamt;
   assign align_m    = {align_full[53:28], align_full[27] | (|align_full[26:0])};

   // Effective subtract on differing signs
   assign add_sum = (fl.sign != fs.sign) ?
                    {2'b01, fl.man, 3'b000} - {1'b0, align_m} :
                    {2'b01, fl.man, 3'b000} + {1'b0, align_m};

   assign mul_prod = {1'b1, fa.man} * {1'b1, fb.man};

   always_comb begin
      s1_spec_d     = 1'b1;
      s1_spec_rsp_d = '0;
      // Sum hidden bit sits at bit 46 like the product
      s1_sign_d     = fl.sign;
      s1_exp_d      = {2'b00, fl.exp};
      s1_mant_d     = {add_sum, 20'd0};
      if (req_i.op == FPU_MUL) begin
         s1_sign_d = fa.sign ^ fb.sign;
         s1_exp_d  = ea + eb - 10'(EXP_BIAS);
         s1_mant_d = mul_prod;
         if (a_nan | b_nan) begin
            s1_spec_rsp_d.result = CANON_NAN;
         end else if ((a_inf & b_zero) | (a_zero & b_inf)) begin
            s1_spec_rsp_d.result   = CANON_NAN;
            s1_spec_rsp_d.flags.nv = 1'b1;
         end else if (a_inf | b_inf) begin
            s1_spec_rsp_d.result = {fa.sign ^ fb.sign, 8'(EXP_MAX), 23'd0};
         end else if (a_zero | b_zero) begin
            s1_spec_rsp_d.result = {fa.sign ^ fb.sign, 31'd0};
         end else begin
            s1_spec_d = 1'b0;
         end
      end else begin
         if (a_nan | b_nan) begin
            s1_spec_rsp_d.result = CANON_NAN;
         end else if (a_inf & b_inf & (fa.sign != fb.sign)) begin
            // inf - inf
            s1_spec_rsp_d.result   = CANON_NAN;
            s1_spec_rsp_d.flags.nv = 1'b1;
         end else if (a_inf) begin
            s1_spec_rsp_d.result = {fa.sign, 8'(EXP_MAX), 23'd0};
         end else if (b_inf) begin
            s1_spec_rsp_d.result = {fb.sign, 8'(EXP_MAX), 23'd0};
         end else if (a_zero & b_zero) begin
            // Only -0 + -0 keeps the minus
            s1_spec_rsp_d.result = {fa.sign & fb.sign, 31'd0};
         end else if (a_zero) begin
            s1_spec_rsp_d.result = fb;
         end else if (b_zero) begin
            s1_spec_rsp_d.result = fa;
         end else begin
            s1_spec_d = 1'b0;
         end
      end
   end

   ////////////////////
   // Stage 2
   ////////////////////

   assign lz    = lead_zeros(s1_mant);
   assign norm  = s1_mant << lz;
   assign exp_n = s1_exp + 10'sd1 - $signed({4'b0000, lz});

   always_comb begin
      s2_rsp_d = s1_spec_rsp;
      if (!s1_spec) begin
         s2_rsp_d.flags = '0;
         if (s1_mant == 48'd0) begin
            // Exact cancellation gives +0
            s2_rsp_d.result = '0;
         end else if (exp_n >= 10'(EXP_MAX)) begin
            s2_rsp_d.result   = {s1_sign, MAX_FINITE_MAG};
            s2_rsp_d.flags.of = 1'b1;
         end else if (exp_n <= 10'sd0) begin
            s2_rsp_d.result   = {s1_sign, 31'd0};
            s2_rsp_d.flags.uf = 1'b1;
         end else begin
            // Truncate below the 23 fraction bits
            s2_rsp_d.result = {s1_sign, exp_n[7:0], norm[46:24]};
         end
      end
   end

   ////////////////////
   // Registers
   ////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         s1_valid <= 1'b0;
         s2_valid <= 1'b0;
      end else begin
         s1_valid <= en_i;
         s2_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk_i) begin
      if (en_i) begin
         s1_tag      <= tag_i;
         s1_sign     <= s1_sign_d;
         s1_exp      <= s1_exp_d;
         s1_mant     <= s1_mant_d;
         s1_spec     <= s1_spec_d;
         s1_spec_rsp <= s1_spec_rsp_d;
      end
      if (s1_valid) begin
         s2_tag <= s1_tag;
         s2_rsp <= s2_rsp_d;
      end
   end

   assign valid_o    = s2_valid;
   assign rsp_o      = s2_rsp;
   assign tag_o      = s2_tag;
   assign occupied_o = s1_valid | s2_valid;

endmodule

// File: hw/fp_div_iter.sv
`timescale 1ns/100ps

module fp_div_iter #(
   parameter int unsigned TAG_W = 4
) (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   start_i,
   input  logic [31:0]            a_i,
   input  logic [31:0]            b_i,
   input  logic [TAG_W-1:0]       tag_i,
   output logic                   done_o,
   output fpu_ctrl_pkg::fpu_rsp_t rsp_o,
   output logic [TAG_W-1:0]       tag_o,
   output logic                   busy_o
);
   import fp_format_pkg::*;
   import fpu_ctrl_pkg::*;

   // One quotient bit per ITER cycle
   localparam int unsigned QUOT_W = 26;

   typedef enum logic [1:0] {
      IDLE,
      ITER,
      FINISH
   } state_e;

   fp_fields_t        fa;
   fp_fields_t        fb;
   logic              a_zero, b_zero;
   logic              a_inf, b_inf;
   logic              a_nan, b_nan;
   logic              q_sign;
   logic              spec_d;
   fpu_rsp_t          spec_rsp_d;

   state_e            state_q;
   logic [4:0]        cnt_q;
   logic [TAG_W-1:0]  tag_q;
   logic              sign_q;
   logic signed [9:0] exp_q;
   logic [24:0]       rem_q;
   logic [23:0]       div_q;
   logic [QUOT_W-1:0] quot_q;
   logic              spec_q;
   fpu_rsp_t          spec_rsp_q;

   logic [25:0]       trial;
   logic              q_bit;
   logic [24:0]       rem_nxt;
   logic signed [9:0] exp_n;
   logic [22:0]       frac;

   ////////////////////
   // Operand classes
   ////////////////////

   assign fa     = a_i;
   assign fb     = b_i;
   assign a_zero = is_zero(fa);
   assign b_zero = is_zero(fb);
   assign a_inf  = is_inf(fa);
   assign b_inf  = is_inf(fb);
   assign a_nan  = is_nan(fa);
   assign b_nan  = is_nan(fb);
   assign q_sign = fa.sign ^ fb.sign;

   // Specials still run the full count
   always_comb begin
      spec_d     = 1'b1;
      spec_rsp_d = '0;
      if (a_nan | b_nan) begin
         spec_rsp_d.result = CANON_NAN;
      end else if ((a_zero & b_zero) | (a_inf & b_inf)) begin
         spec_rsp_d.result   = CANON_NAN;
         spec_rsp_d.flags.nv = 1'b1;
      end else if (a_inf) begin
         spec_rsp_d.result = {q_sign, 8'(EXP_MAX), 23'd0};
      end else if (b_zero) begin
         // Finite nonzero over zero
         spec_rsp_d.result   = {q_sign, 8'(EXP_MAX), 23'd0};
         spec_rsp_d.flags.dz = 1'b1;
      end else if (a_zero | b_inf) begin
         spec_rsp_d.result = {q_sign, 31'd0};
      end else begin
         spec_d = 1'b0;
      end
   end

   ////////////////////
   // Control FSM
   ////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         state_q <= IDLE;
         cnt_q   <= '0;
      end else begin
         unique case (state_q)
            IDLE: begin
               if (start_i) begin
                  state_q <= ITER;
                  cnt_q   <= 5'(QUOT_W - 1);
               end
            end
            ITER: begin
               if (cnt_q == 5'd0) begin
                  state_q <= FINISH;
               end else begin
                  cnt_q <= cnt_q - 5'd1;
               end
            end
            FINISH:  state_q <= IDLE;
            default: state_q <= IDLE;
         endcase
      end
   end

   ////////////////////
   // Restoring divide
   ////////////////////

   // Borrow out means the divisor did not fit
   assign trial   = {1'b0, rem_q} - {2'b00, div_q};
   assign q_bit   = ~trial[25];
   assign rem_nxt = q_bit ? trial[24:0] : rem_q;

   always_ff @(posedge clk_i) begin
      if ((state_q == IDLE) && start_i) begin
         tag_q      <= tag_i;
         sign_q     <= q_sign;
         exp_q      <= $signed({2'b00, fa.exp}) - $signed({2'b00, fb.exp}) +
                       10'(EXP_BIAS);
         rem_q      <= {2'b01, fa.man};
         div_q      <= {1'b1, fb.man};
         quot_q     <= '0;
         spec_q     <= spec_d;
         spec_rsp_q <= spec_rsp_d;
      end else if (state_q == ITER) begin
         rem_q  <= {rem_nxt[23:0], 1'b0};
         quot_q <= {quot_q[QUOT_W-2:0], q_bit};
      end
   end

   ////////////////////
   // Finish
   ////////////////////

   // Quotient lies in (0.5, 2) so one shift at most
   assign exp_n = quot_q[QUOT_W-1] ? exp_q : exp_q - 10'sd1;
   assign frac  = quot_q[QUOT_W-1] ? quot_q[24:2] : quot_q[23:1];

   always_comb begin
      rsp_o = spec_rsp_q;
      if (!spec_q) begin
         rsp_o.flags = '0;
         if (exp_n >= 10'(EXP_MAX)) begin
            rsp_o.result   = {sign_q, MAX_FINITE_MAG};
            rsp_o.flags.of = 1'b1;
         end else if (exp_n <= 10'sd0) begin
            rsp_o.result   = {sign_q, 31'd0};
            rsp_o.flags.uf = 1'b1;
         end else begin
            rsp_o.result = {sign_q, exp_n[7:0], frac};
         end
      end
   end

   assign done_o = (state_q == FINISH);
   assign busy_o = (state_q != IDLE);
   assign tag_o  = tag_q;

endmodule

// File: hw/fpu_top.sv
`timescale 1ns/100ps

module fpu_top #(
   parameter int unsigned TAG_W = 4
) (
   input  logic                   clk_i,
   input  logic                   rst_i,
   input  logic                   fpu_en_i,
   input  fpu_ctrl_pkg::fpu_req_t req_i,
   input  logic [TAG_W-1:0]       tag_i,
   output logic                   valid_o,
   output fpu_ctrl_pkg::fpu_rsp_t rsp_o,
   output logic [TAG_W-1:0]       tag_o,
   output logic                   busy_o
);
   import fpu_ctrl_pkg::*;

   logic             accept;
   logic             core_en;
   logic             div_start;
   logic             core_valid;
   logic             core_occupied;
   fpu_rsp_t         core_rsp;
   logic [TAG_W-1:0] core_tag;
   logic             div_done;
   logic             div_busy;
   fpu_rsp_t         div_rsp;
   logic [TAG_W-1:0] div_tag;

   ////////////////////
   // Decode
   ////////////////////

   // Any enable while busy is dropped
   assign accept = fpu_en_i & ~busy_o;

   always_comb begin
      core_en   = 1'b0;
      div_start = 1'b0;
      if (accept) begin
         unique case (req_i.op)
            FPU_ADD, FPU_SUB, FPU_MUL: core_en   = 1'b1;
            FPU_DIV:                   div_start = 1'b1;
            default:                   core_en   = 1'b0;
         endcase
      end
   end

   // Divide waits for an empty core, core waits for the divider
   assign busy_o = div_busy | core_occupied;

   ////////////////////
   // Units
   ////////////////////

   fp_addmul_core #(
      .TAG_W ( TAG_W )
   ) i_fp_addmul_core (
      .clk_i      ( clk_i         ),
      .rst_i      ( rst_i         ),
      .en_i       ( core_en       ),
      .req_i      ( req_i         ),
      .tag_i      ( tag_i         ),
      .valid_o    ( core_valid    ),
      .rsp_o      ( core_rsp      ),
      .tag_o      ( core_tag      ),
      .occupied_o ( core_occupied )
   );

   fp_div_iter #(
      .TAG_W ( TAG_W )
   ) i_fp_div_iter (
      .clk_i   ( clk_i     ),
      .rst_i   ( rst_i     ),
      .start_i ( div_start ),
      .a_i     ( req_i.a   ),
      .b_i     ( req_i.b   ),
      .tag_i   ( tag_i     ),
      .done_o  ( div_done  ),
      .rsp_o   ( div_rsp   ),
      .tag_o   ( div_tag   ),
      .busy_o  ( div_busy  )
   );

   ////////////////////
   // Result merge
   ////////////////////

   // Strobes are exclusive by the busy rule
   assign valid_o = div_done | core_valid;
   assign rsp_o   = div_done ? div_rsp : core_valid ? core_rsp : '0;
   assign tag_o   = div_done ? div_tag : core_valid ? core_tag : '0;

endmodule

// File: verif/fpu_chk.sv
`timescale 1ns/100ps

module fpu_chk (
   input logic clk_i,
   input logic rst_i,
   input logic valid_o,
   input logic busy_o,
   input logic core_valid,
   input logic div_done,
   input logic core_en,
   input logic div_start
);
   int fail_count = 0;

   // Output quiet while held in reset
   assert property (@(posedge clk_i) rst_i |=> !valid_o)
      else begin
         $error("valid_o high during reset");
         fail_count++;
      end

   assert property (@(posedge clk_i) disable iff (rst_i) !(core_valid && div_done))
      else begin
         $error("Core and divider valid together");
         fail_count++;
      end

   // An accepted request raises busy on the next cycle
   assert property (@(posedge clk_i) disable iff (rst_i)
                    (core_en || div_start) |=> busy_o)
      else begin
         $error("Busy not raised after a unit enable");
         fail_count++;
      end

endmodule

bind fpu_top fpu_chk i_fpu_chk (
   .clk_i      ( clk_i      ),
   .rst_i      ( rst_i      ),
   .valid_o    ( valid_o    ),
   .busy_o     ( busy_o     ),
   .core_valid ( core_valid ),
   .div_done   ( div_done   ),
   .core_en    ( core_en    ),
   .div_start  ( div_start  )
);

// File: verif/fpu_ref.svh
`ifndef FPU_REF_SVH
`define FPU_REF_SVH

// Expected result and flags of one request under round toward zero
function automatic fpu_rsp_t expected_rsp(input fpu_op_e op, input logic [31:0] a,
                                          input logic [31:0] b);
   fpu_rsp_t    r;
   logic        sa, sb, sl, ss, rs, fin;
   logic        a0, b0, ai, bi, an, bn;
   int          ea, eb, el, es, diff, msb, e;
   logic [23:0] ma, mb;
   logic [63:0] ml, ms, lost;
   logic [64:0] sum, norm;
   logic [47:0] prod;
   logic [48:0] quo;
   logic [22:0] frac;
   r    = '0;
   fin  = 1'b0;
   rs   = 1'b0;
   e    = 0;
   frac = '0;
   sa   = a[31];
   // Subtract seen as add of the negated b
   sb   = b[31] ^ (op == FPU_SUB);
   ea   = a[30:23];
   eb   = b[30:23];
   ma   = {1'b1, a[22:0]};
   mb   = {1'b1, b[22:0]};
   a0   = (ea == 0);
   b0   = (eb == 0);
   ai   = (ea == 255) && (a[22:0] == 0);
   bi   = (eb == 255) && (b[22:0] == 0);
   an   = (ea == 255) && (a[22:0] != 0);
   bn   = (eb == 255) && (b[22:0] != 0);
   if (an || bn) begin
      r.result = 32'h7fc00000;
      return r;
   end
   case (op)
      FPU_ADD, FPU_SUB: begin
         if (ai && bi && (sa != sb)) begin
            r.result   = 32'h7fc00000;
            r.flags.nv = 1'b1;
         end else if (ai) r.result = {sa, 8'hff, 23'd0};
         else if (bi) r.result = {sb, 8'hff, 23'd0};
         else if (a0 && b0) r.result = {sa & sb, 31'd0};
         else if (a0) r.result = {sb, b[30:0]};
         else if (b0) r.result = a;
         else begin
            // Larger magnitude on the left
            if (a[30:0] >= b[30:0]) begin
               sl = sa;
               el = ea;
               ml = {ma, 40'd0};
               ss = sb;
               es = eb;
               ms = {mb, 40'd0};
            end else begin
               sl = sb;
               el = eb;
               ml = {mb, 40'd0};
               ss = sa;
               es = ea;
               ms = {ma, 40'd0};
            end
            diff = el - es;
            // Far below the kept bits only a sticky one matters
            if (diff >= 64) begin
               ms = 64'd1;
            end else begin
               lost = ms & ((64'd1 << diff) - 64'd1);
               ms   = ms >> diff;
               if (lost != 0) ms[0] = 1'b1;
            end
            sum = (sl == ss) ? {1'b0, ml} + {1'b0, ms} : {1'b0, ml} - {1'b0, ms};
            if (sum == 0) begin
               r.result = 32'd0;
            end else begin
               msb = 0;
               for (int i = 0; i < 65; i++) begin
                  if (sum[i]) msb = i;
               end
               norm = (msb >= 23) ? (sum >> (msb - 23)) : (sum << (23 - msb));
               frac = norm[22:0];
               e    = el + msb - 63;
               rs   = sl;
               fin  = 1'b1;
            end
         end
      end
      FPU_MUL: begin
         if ((ai && b0) || (a0 && bi)) begin
            r.result   = 32'h7fc00000;
            r.flags.nv = 1'b1;
         end else if (ai || bi) r.result = {sa ^ sb, 8'hff, 23'd0};
         else if (a0 || b0) r.result = {sa ^ sb, 31'd0};
         else begin
            prod = ma * mb;
            msb  = prod[47] ? 47 : 46;
            frac = 23'(prod >> (msb - 23));
            e    = ea + eb - 127 + msb - 46;
            rs   = sa ^ sb;
            fin  = 1'b1;
         end
      end
      default: begin
         if ((a0 && b0) || (ai && bi)) begin
            r.result   = 32'h7fc00000;
            r.flags.nv = 1'b1;
         end else if (ai) r.result = {sa ^ sb, 8'hff, 23'd0};
         else if (b0) begin
            r.result   = {sa ^ sb, 8'hff, 23'd0};
            r.flags.dz = 1'b1;
         end else if (a0 || bi) r.result = {sa ^ sb, 31'd0};
         else begin
            // Exact floor of the scaled quotient
            quo = {ma, 25'd0} / mb;
            if (quo[25]) begin
               frac = quo[24:2];
               e    = ea - eb + 127;
            end else begin
               frac = quo[23:1];
               e    = ea - eb + 126;
            end
            rs  = sa ^ sb;
            fin = 1'b1;
         end
      end
   endcase
   if (fin) begin
      if (e >= 255) begin
         r.result   = {rs, 31'h7f7fffff};
         r.flags.of = 1'b1;
      end else if (e <= 0) begin
         r.result   = {rs, 31'd0};
         r.flags.uf = 1'b1;
      end else begin
         r.result = {rs, 8'(e), frac};
      end
   end
   return r;
endfunction

`endif

// File: verif/tb_fpu.sv
`timescale 1ns/100ps

module tb_fpu;
   import fpu_ctrl_pkg::*;

   localparam int TAG_W       = 4;
   localparam int CLK_PERIOD  = 100;
   // Cycles from the request cycle to the visible result
   localparam int CORE_LAT    = 2;
   localparam int DIV_LAT     = 27;
   localparam int N_RAND_CORE = 40;
   localparam int N_RAND_DIV  = 12;
   localparam int N_DIR       = 19;
   localparam int N_CORE_OPS  = N_RAND_CORE + 11 + 1;
   localparam int N_DIV_OPS   = N_RAND_DIV + 8 + 1;
   localparam longint TIMEOUT =
      2 * (N_CORE_OPS * 3 + N_DIV_OPS * 30 + 20) * CLK_PERIOD;

   // One outstanding request
   typedef struct packed {
      fpu_rsp_t         rsp;
      logic [TAG_W-1:0] tag;
      logic             is_div;
      logic [31:0]      start_cyc;
      logic [31:0]      exp_cyc;
   } pend_t;

   // Special operands as {op, a, b}
   localparam logic [65:0] DIR_TAB [N_DIR] = '{
      {2'd1, 32'h7f800000, 32'h7f800000},  // inf - inf
      {2'd2, 32'h00000000, 32'h7f800000},  // 0 * inf
      {2'd0, 32'h7fc00001, 32'h3f800000},  // NaN in
      {2'd2, 32'h7f000000, 32'h7f000000},  // Overflow
      {2'd2, 32'h00800000, 32'h00800000},  // Underflow
      {2'd0, 32'h00400000, 32'h3f800000},  // Subnormal plus one
      {2'd2, 32'h00400000, 32'h3f800000},
      {2'd1, 32'h3f800000, 32'h3f800000},  // Exact cancel
      {2'd0, 32'h80000000, 32'h80000000},
      {2'd0, 32'h7f7fffff, 32'h7f7fffff},
      {2'd1, 32'h00800001, 32'h00800000},
      {2'd3, 32'h00000000, 32'h00000000},  // 0/0
      {2'd3, 32'h7f800000, 32'hff800000},  // inf/inf
      {2'd3, 32'h3f800000, 32'h00000000},  // Divide by zero
      {2'd3, 32'hbf800000, 32'h80000000},
      {2'd3, 32'h7f000000, 32'h00800000},
      {2'd3, 32'h00800000, 32'h7f000000},
      {2'd3, 32'h3f800000, 32'h7f800000},  // x/inf
      {2'd3, 32'h40400000, 32'h3f800000}
   };

   logic             clk_i;
   logic             rst_i;
   logic             fpu_en_i;
   fpu_req_t         req_i;
   logic [TAG_W-1:0] tag_i;
   logic             valid_o;
   fpu_rsp_t         rsp_o;
   logic [TAG_W-1:0] tag_o;
   logic             busy_o;

   logic [31:0]      cyc;
   logic [31:0]      rnd_state;
   logic [TAG_W-1:0] next_tag;
   pend_t            pend [$];

   `include "fpu_ref.svh"

   fpu_top #(
      .TAG_W ( TAG_W )
   ) i_fpu_top (
      .clk_i    ( clk_i    ),
      .rst_i    ( rst_i    ),
      .fpu_en_i ( fpu_en_i ),
      .req_i    ( req_i    ),
      .tag_i    ( tag_i    ),
      .valid_o  ( valid_o  ),
      .rsp_o    ( rsp_o    ),
      .tag_o    ( tag_o    ),
      .busy_o   ( busy_o   )
   );

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cyc <= cyc + 32'd1;
   end

   ////////////////////
   // Helpers
   ////////////////////

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Mostly moderate exponents so results stay finite
   task automatic rand_operand(output logic [31:0] v);
      rnd_state = xorshift(rnd_state);
      if (rnd_state[1:0] == 2'd0) begin
         v = rnd_state;
      end else begin
         v = {rnd_state[31], 8'(8'd100 + rnd_state[10:5]), rnd_state[30:8]};
      end
   endtask

   task automatic stop_fail();
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic abort_run(input string why);
      $display("%0t ns: %s", $time, why);
      stop_fail();
   endtask

   task automatic check_equal(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
         stop_fail();
      end
   endtask

   // One stimulus cycle queued only if the DUT takes it
   task automatic drive_cycle(input logic en, input fpu_op_e op, input logic [31:0] a,
                              input logic [31:0] b, output logic taken);
      pend_t p;
      @(posedge clk_i);
      #10;
      fpu_en_i = en;
      req_i    = '{op: op, a: a, b: b};
      tag_i    = next_tag;
      taken    = en & ~busy_o;
      if (en) begin
         next_tag = next_tag + 1'b1;
      end
      if (taken) begin
         p.rsp       = expected_rsp(op, a, b);
         p.tag       = tag_i;
         p.is_div    = (op == FPU_DIV);
         p.start_cyc = cyc + 32'd1;
         p.exp_cyc   = cyc + ((op == FPU_DIV) ? DIV_LAT : CORE_LAT);
         pend.push_back(p);
      end
   endtask

   task automatic issue_until_accepted(input fpu_op_e op, input logic [31:0] a,
                                       input logic [31:0] b);
      logic taken;
      taken = 1'b0;
      while (!taken) begin
         drive_cycle(1'b1, op, a, b, taken);
      end
   endtask

   ////////////////////
   // Compare
   ////////////////////

   always @(negedge clk_i) begin
      pend_t e;
      if (!rst_i) begin
         // Whole divide keeps busy up
         if (pend.size() > 0 && pend[0].is_div && cyc >= pend[0].start_cyc) begin
            check_equal("busy_o", 64'(busy_o), 64'd1);
         end
         if (valid_o) begin
            if (pend.size() == 0) begin
               abort_run("valid_o rose with no request outstanding");
            end else begin
               e = pend.pop_front();
               check_equal("rsp_o.result", 64'(rsp_o.result), 64'(e.rsp.result));
               check_equal("rsp_o.flags", 64'(rsp_o.flags), 64'(e.rsp.flags));
               check_equal("tag_o", 64'(tag_o), 64'(e.tag));
               check_equal("valid_o cycle", 64'(cyc), 64'(e.exp_cyc));
            end
         end
      end
   end

   initial begin
      #(TIMEOUT);
      abort_run("Timed out waiting for the outstanding results");
   end

   ////////////////////
   // Stimulus
   ////////////////////

   initial begin
      logic [31:0] a;
      logic [31:0] b;
      logic        taken;
      clk_i     = 1'b0;
      rst_i     = 1'b1;
      fpu_en_i  = 1'b0;
      req_i     = '0;
      tag_i     = '0;
      cyc       = '0;
      next_tag  = '0;
      rnd_state = 32'h7b86;
      repeat (10) @(posedge clk_i);
      #10;
      rst_i = 1'b0;

      for (int i = 0; i < N_DIR; i++) begin
         issue_until_accepted(fpu_op_e'(DIR_TAB[i][65:64]), DIR_TAB[i][63:32],
                              DIR_TAB[i][31:0]);
      end

      // Back to back tries where those hitting busy are dropped
      for (int i = 0; i < N_RAND_CORE; i++) begin
         rand_operand(a);
         rand_operand(b);
         if (i % 6 == 0) begin
            // Same exponent and opposite sign on ADD for cancellation
            b = {~a[31], a[30:23], b[22:0]};
         end
         issue_until_accepted(fpu_op_e'(i % 3), a, b);
      end

      for (int i = 0; i < N_RAND_DIV; i++) begin
         rand_operand(a);
         rand_operand(b);
         issue_until_accepted(FPU_DIV, a, b);
         repeat (3) begin
            drive_cycle(1'b1, FPU_ADD, a, b, taken);
            if (taken) begin
               abort_run("Request taken while a divide was running");
            end
         end
      end

      // Divide right behind a core op
      issue_until_accepted(FPU_MUL, 32'h40000000, 32'h40400000);
      issue_until_accepted(FPU_DIV, 32'h40e00000, 32'h40000000);

      while (pend.size() != 0) begin
         drive_cycle(1'b0, FPU_ADD, 32'd0, 32'd0, taken);
      end
      repeat (5) begin
         drive_cycle(1'b0, FPU_ADD, 32'd0, 32'd0, taken);
      end

      if (i_fpu_top.i_fpu_chk.fail_count != 0) begin
         abort_run("Bound assertions reported failures");
      end else begin
         $display("Simulation finished: PASS");
         $finish;
      end
   end

endmodule

// File: all.f
+incdir+verif
hw/fp_format_pkg.sv
hw/fpu_ctrl_pkg.sv
hw/fp_addmul_core.sv
hw/fp_div_iter.sv
hw/fpu_top.sv
verif/fpu_chk.sv
verif/tb_fpu.sv

// File: Bender.yml
package:
  name: fpu

sources:
  - files:
      - hw/fp_format_pkg.sv
      - hw/fpu_ctrl_pkg.sv
      - hw/fp_addmul_core.sv
      - hw/fp_div_iter.sv
      - hw/fpu_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/fpu_chk.sv
      - verif/tb_fpu.sv
